// ==== hw/armAddrPkg.sv ====
package armAddrPkg;

  // ============================
  // Basic widths
  // ============================

  // Architectural register number R0 to R15
  typedef logic [3:0]  archReg_t;
  // One-hot physical register select, all zero means no register
  typedef logic [31:0] physRegSel_t;
  // Bit position inside a physical select
  typedef logic [4:0]  physIdx_t;
  // Instruction word and fetch address
  typedef logic [31:0] instr_t;
  typedef logic [31:0] addr_t;
  // Low byte of the status register, mode in bits 4:0
  typedef logic [7:0]  statusByte_t;
  // Exception requests, bit 0 has highest priority
  // reset, dabt, fiq, irq, pabt, swi, und
  typedef logic [6:0]  vectorReq_t;

  // Status register mode field
  typedef enum logic [4:0] {
    USER = 5'b10000,
    FIQ  = 5'b10001,
    IRQ  = 5'b10010,
    SVC  = 5'b10011,
    ABT  = 5'b10111,
    UND  = 5'b11011,
    SYS  = 5'b11111
  } cpuMode_t;

  // ============================
  // Bundles
  // ============================

  // Decode-stage operand field controls
  typedef struct packed {
    logic       multSelect;
    logic [1:0] regSrc;
    logic       shiftByReg;
  } opSelCtrl_t;

  // Hazard unit address matches
  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match1DE;
    logic match2DE;
  } matchFlags_t;

  // ============================
  // Bank map
  // ============================

  // First bit of each bank in a physical select
  localparam physIdx_t USR_HI_BASE = 5'd8;
  localparam physIdx_t FIQ_HI_BASE = 5'd13;
  localparam physIdx_t USR_SP_BASE = 5'd18;
  localparam physIdx_t FIQ_SP_BASE = 5'd20;
  localparam physIdx_t IRQ_SP_BASE = 5'd22;
  localparam physIdx_t SVC_SP_BASE = 5'd24;
  localparam physIdx_t ABT_SP_BASE = 5'd26;
  localparam physIdx_t UND_SP_BASE = 5'd28;
  // Program counter, same in every mode
  localparam physIdx_t PC_BIT      = 5'd30;

endpackage

// ==== hw/operandSelect.sv ====
`timescale 1ns/100ps

module operandSelect import armAddrPkg::*; (
  input  instr_t     instr,
  input  opSelCtrl_t ctrl,
  output archReg_t   ra1,
  output archReg_t   ra2,
  output archReg_t   destReg
);

  // Rn field or forced PC
  archReg_t ra1Rn;

  assign ra1Rn = ctrl.regSrc[0] ? 4'd15 : instr[19:16];

  // First read port
  // multiply Rm wins over register-specified shift
  always_comb begin
    if (ctrl.multSelect) begin
      ra1 = instr[3:0];
    end else if (ctrl.shiftByReg) begin
      // Rs holds the shift amount
      ra1 = instr[11:8];
    end else begin
      ra1 = ra1Rn;
    end
  end

  // Second read port
  always_comb begin
    if (ctrl.multSelect) begin
      // Rs of the multiply
      ra2 = instr[11:8];
    end else if (ctrl.regSrc[1]) begin
      // Rd as source, stores
      ra2 = instr[15:12];
    end else begin
      ra2 = instr[3:0];
    end
  end

  // Destination, multiplies keep Rd in 19:16
  assign destReg = ctrl.multSelect ? instr[19:16] : instr[15:12];

endmodule

// ==== hw/bankedRegDecode.sv ====
`timescale 1ns/100ps

module bankedRegDecode import armAddrPkg::*; (
  input  archReg_t    regNum,
  input  cpuMode_t    mode,
  output physRegSel_t sel
);

  // Base of the banked R13/R14 pair for this mode
  physIdx_t spBase;
  // Base of the R8-R12 bank
  physIdx_t hiBase;
  // Selected physical bit
  physIdx_t bitIdx;

  // ============================
  // Bank choice per mode
  // ============================

  always_comb begin
    case (mode)
      FIQ:     spBase = FIQ_SP_BASE;
      IRQ:     spBase = IRQ_SP_BASE;
      SVC:     spBase = SVC_SP_BASE;
      ABT:     spBase = ABT_SP_BASE;
      UND:     spBase = UND_SP_BASE;
      // User, system and any bad encoding
      default: spBase = USR_SP_BASE;
    endcase
  end

  // Only FIQ has its own R8-R12
  assign hiBase = (mode == FIQ) ? FIQ_HI_BASE : USR_HI_BASE;

  // ============================
  // Register to bit position
  // ============================

  always_comb begin
    if (regNum == 4'd15) begin
      // PC is never banked
      bitIdx = PC_BIT;
    end else if (regNum < 4'd8) begin
      // Low registers shared by all modes
      bitIdx = {1'b0, regNum};
    end else if (regNum < 4'd13) begin
      // R8..R12 give offsets 0..4
      bitIdx = hiBase + {2'b00, regNum[2:0]};
    end else begin
      // R13 -> +0, R14 -> +1
      bitIdx = spBase + {4'b0000, regNum[1]};
    end
  end

  // One-hot output
  always_comb begin
    sel = '0;
    sel[bitIdx] = 1'b1;
  end

endmodule

// ==== hw/exceptionVector.sv ====
`timescale 1ns/100ps

module exceptionVector import armAddrPkg::*; #(
  parameter addr_t VECTOR_BASE = 32'h0000_0000
) (
  input  vectorReq_t req,
  output addr_t      pcNext,
  output logic       vectorSelect
);

  // Vector table offsets
  localparam addr_t OFF_RESET = 32'h0000_0000;
  localparam addr_t OFF_UND   = 32'h0000_0004;
  localparam addr_t OFF_SWI   = 32'h0000_0008;
  localparam addr_t OFF_PABT  = 32'h0000_000C;
  localparam addr_t OFF_DABT  = 32'h0000_0010;
  localparam addr_t OFF_IRQ   = 32'h0000_0018;
  localparam addr_t OFF_FIQ   = 32'h0000_001C;

  addr_t offset;

  // Lowest set bit wins
  always_comb begin
    if (req[0])      offset = OFF_RESET;
    else if (req[1]) offset = OFF_DABT;
    else if (req[2]) offset = OFF_FIQ;
    else if (req[3]) offset = OFF_IRQ;
    else if (req[4]) offset = OFF_PABT;
    else if (req[5]) offset = OFF_SWI;
    else if (req[6]) offset = OFF_UND;
    // no request, plain base
    else             offset = '0;
  end

  // Base is 64K aligned so no carry into the upper half
  assign pcNext       = VECTOR_BASE | offset;
  assign vectorSelect = |req;

endmodule

// ==== hw/addressPath.sv ====
`timescale 1ns/100ps

module addressPath import armAddrPkg::*; #(
  parameter addr_t VECTOR_BASE = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,
  // Instruction words
  input  instr_t      instrD,
  input  instr_t      instrE,
  // Controller strobes
  input  opSelCtrl_t  opCtrlD,
  input  logic        writeMultLoE,
  input  logic        swiE,
  input  statusByte_t statusW,
  input  vectorReq_t  vectorReqW,
  // Hazard unit levels
  input  logic        stallE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  // Register file selects
  output physRegSel_t ra1D,
  output physRegSel_t ra2D,
  output physRegSel_t wa3W,
  // Fetch redirect
  output addr_t       vectorPcNextF,
  output logic        vectorSelectW,
  // To hazard unit
  output matchFlags_t match
);

  // Architectural fields in decode
  archReg_t    ra1ArchD;
  archReg_t    ra2ArchD;
  archReg_t    destArchD;
  // Mode as seen by the decoders
  cpuMode_t    modeW;
  cpuMode_t    modeD;
  // Physical selects along the pipe
  physRegSel_t wa3D;
  physRegSel_t wa3RegE;
  physRegSel_t wa3E;
  physRegSel_t rdLoE;
  physRegSel_t ra1E;
  physRegSel_t ra2E;
  physRegSel_t wa3M;

  // ==============================
  // Decode
  // ==============================

  operandSelect opSel (
    .instr   (instrD),
    .ctrl    (opCtrlD),
    .ra1     (ra1ArchD),
    .ra2     (ra2ArchD),
    .destReg (destArchD)
  );

  // Mode field of the committed status
  assign modeW = cpuMode_t'(statusW[4:0]);
  // SWI in execute switches banks to supervisor early
  assign modeD = swiE ? SVC : modeW;

  bankedRegDecode ra1Dec (.regNum(ra1ArchD),  .mode(modeD), .sel(ra1D));
  bankedRegDecode ra2Dec (.regNum(ra2ArchD),  .mode(modeD), .sel(ra2D));
  bankedRegDecode wa3Dec (.regNum(destArchD), .mode(modeD), .sel(wa3D));

  // ==============================
  // Execute
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      wa3RegE <= '0;
      ra1E    <= '0;
      ra2E    <= '0;
    end else if (!stallE) begin
      wa3RegE <= wa3D;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
    end
  end

  // RdLo of a long multiply, field 15:12
  bankedRegDecode rdLoDec (.regNum(instrE[15:12]), .mode(modeW), .sel(rdLoE));

  // Second write cycle of a long multiply
  assign wa3E = writeMultLoE ? rdLoE : wa3RegE;

  // ==============================
  // Memory
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      wa3M <= '0;
    end else if (!stallM) begin
      wa3M <= wa3E;
    end
  end

  // ==============================
  // Writeback
  // ==============================

  // Flush beats stall
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      wa3W <= '0;
    end else if (!stallW) begin
      wa3W <= wa3M;
    end
  end

  // Hazard matches as one-hot overlap
  // empty select never matches
  assign match.match1EM = |(ra1E & wa3M);
  assign match.match1EW = |(ra1E & wa3W);
  assign match.match2EM = |(ra2E & wa3M);
  assign match.match2EW = |(ra2E & wa3W);
  // Decode reads against execute write, load-use stall
  assign match.match1DE = |(ra1D & wa3E);
  assign match.match2DE = |(ra2D & wa3E);

  // Exception entry, feeds the fetch mux
  exceptionVector #(
    .VECTOR_BASE (VECTOR_BASE)
  ) excVec (
    .req          (vectorReqW),
    .pcNext       (vectorPcNextF),
    .vectorSelect (vectorSelectW)
  );

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset high for the first edges, released just after an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== testbench/addressPathTb.sv ====
`timescale 1ns/100ps

module addressPathTb import armAddrPkg::*; ();

  // ============================
  // Run length and limits
  // ============================

  localparam addr_t HIGH_BASE      = 32'hFFFF_0000;
  localparam int    STIM_CYCLES    = 1500;
  // Stall free warm-up part of the stimulus
  localparam int    CLEAN_CYCLES   = 300;
  localparam int    TIMEOUT_CYCLES = 2 * STIM_CYCLES;

  logic        clk;
  logic        reset;
  instr_t      instrD;
  instr_t      instrE;
  opSelCtrl_t  opCtrlD;
  logic        writeMultLoE;
  logic        swiE;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  statusByte_t statusW;
  vectorReq_t  vectorReqW;
  physRegSel_t ra1D;
  physRegSel_t ra2D;
  physRegSel_t wa3W;
  addr_t       vectorPcNextF;
  logic        vectorSelectW;
  matchFlags_t matchOut;

  // Model of the pipeline selects
  physRegSel_t mWa3E;
  physRegSel_t mRa1E;
  physRegSel_t mRa2E;
  physRegSel_t mWa3M;
  physRegSel_t mWa3W;
  logic        flushSeen;

  int selErrors;
  int flagErrors;
  int vectorErrors;
  int cycleCount;

  clockGen clkGen (.clk(clk), .reset(reset));

  addressPath #(.VECTOR_BASE(HIGH_BASE)) UUT (
    .clk (clk), .reset (reset), .instrD (instrD), .instrE (instrE),
    .opCtrlD (opCtrlD), .writeMultLoE (writeMultLoE), .swiE (swiE),
    .statusW (statusW), .vectorReqW (vectorReqW), .stallE (stallE),
    .stallM (stallM), .stallW (stallW), .flushW (flushW), .ra1D (ra1D),
    .ra2D (ra2D), .wa3W (wa3W), .vectorPcNextF (vectorPcNextF),
    .vectorSelectW (vectorSelectW), .match (matchOut)
  );

  // ============================
  // Reference rules
  // ============================

  // Bank map, bad modes act as user
  function automatic physRegSel_t bankedSel(input archReg_t r, input logic [4:0] m);
    physRegSel_t sel;
    int idx;
    int spBase;
    sel = '0;
    case (m)
      FIQ:     spBase = 20;
      IRQ:     spBase = 22;
      SVC:     spBase = 24;
      ABT:     spBase = 26;
      UND:     spBase = 28;
      default: spBase = 18;
    endcase
    if (r == 4'd15) idx = 30;
    else if (r < 4'd8) idx = int'(r);
    else if (r < 4'd13) idx = ((m == FIQ) ? 13 : 8) + int'(r) - 8;
    else idx = spBase + int'(r) - 13;
    sel[idx] = 1'b1;
    return sel;
  endfunction

  // Operand and destination fields
  task automatic splitFields(input instr_t i, input opSelCtrl_t c,
                             output archReg_t a1, output archReg_t a2, output archReg_t d);
    if (c.multSelect) a1 = i[3:0];
    else if (c.shiftByReg) a1 = i[11:8];
    else if (c.regSrc[0]) a1 = 4'd15;
    else a1 = i[19:16];
    if (c.multSelect) a2 = i[11:8];
    else if (c.regSrc[1]) a2 = i[15:12];
    else a2 = i[3:0];
    d = c.multSelect ? i[19:16] : i[15:12];
  endtask

  // Decode selects from the current inputs, SWI forces supervisor
  task automatic decodeSelects(output physRegSel_t s1, output physRegSel_t s2,
                               output physRegSel_t sd);
    archReg_t a1;
    archReg_t a2;
    archReg_t d;
    logic [4:0] m;
    m = swiE ? SVC : statusW[4:0];
    splitFields(instrD, opCtrlD, a1, a2, d);
    s1 = bankedSel(a1, m);
    s2 = bankedSel(a2, m);
    sd = bankedSel(d, m);
  endtask

  // Long multiply low destination in execute
  function automatic physRegSel_t multLoSel();
    return bankedSel(instrE[15:12], statusW[4:0]);
  endfunction

  // Vector table, bit 0 has the highest priority
  function automatic addr_t vectorTarget(input vectorReq_t req);
    addr_t pc;
    pc = HIGH_BASE;
    for (int i = 6; i >= 0; i--) begin
      if (req[i]) begin
        case (i)
          0: pc = HIGH_BASE + 32'h00;
          1: pc = HIGH_BASE + 32'h10;
          2: pc = HIGH_BASE + 32'h1C;
          3: pc = HIGH_BASE + 32'h18;
          4: pc = HIGH_BASE + 32'h0C;
          5: pc = HIGH_BASE + 32'h08;
          default: pc = HIGH_BASE + 32'h04;
        endcase
      end
    end
    return pc;
  endfunction

  // ============================
  // Compare tasks
  // ============================

  task automatic checkSel(input string what, input physRegSel_t got, input physRegSel_t exp);
    if (got !== exp) begin
      selErrors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlags(input matchFlags_t got, input matchFlags_t exp);
    if (got !== exp) begin
      flagErrors++;
      $display("ERROR at %0t: match flags got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic checkVector(input addr_t gotPc, input logic gotSel,
                             input addr_t expPc, input logic expSel);
    if (gotPc !== expPc || gotSel !== expSel) begin
      vectorErrors++;
      $display("ERROR at %0t: vector got %h/%b expected %h/%b",
               $time, gotPc, gotSel, expPc, expSel);
    end
  endtask

  // ============================
  // Pipeline model
  // ============================

  always @(posedge clk) begin : modelUpdate
    physRegSel_t d1;
    physRegSel_t d2;
    physRegSel_t dw;
    physRegSel_t effE;
    if (reset) begin
      mWa3E = '0;
      mRa1E = '0;
      mRa2E = '0;
      mWa3M = '0;
      mWa3W = '0;
      flushSeen = 1'b0;
    end else begin
      decodeSelects(d1, d2, dw);
      effE = writeMultLoE ? multLoSel() : mWa3E;
      flushSeen = flushW;
      // Flush beats stall in writeback
      if (flushW) mWa3W = '0;
      else if (!stallW) mWa3W = mWa3M;
      if (!stallM) mWa3M = effE;
      if (!stallE) begin
        mWa3E = dw;
        mRa1E = d1;
        mRa2E = d2;
      end
    end
  end

  // Compare in the middle of the cycle, inputs settled
  always @(negedge clk) begin : compareOutputs
    physRegSel_t e1;
    physRegSel_t e2;
    physRegSel_t ed;
    physRegSel_t effE;
    matchFlags_t expFlags;
    if (!reset) begin
      decodeSelects(e1, e2, ed);
      effE = writeMultLoE ? multLoSel() : mWa3E;
      checkSel("ra1D", ra1D, e1);
      checkSel("ra2D", ra2D, e2);
      checkSel("wa3W", wa3W, mWa3W);
      if (flushSeen) checkSel("wa3W after flush", wa3W, '0);
      expFlags.match1EM = |(mRa1E & mWa3M);
      expFlags.match1EW = |(mRa1E & mWa3W);
      expFlags.match2EM = |(mRa2E & mWa3M);
      expFlags.match2EW = |(mRa2E & mWa3W);
      expFlags.match1DE = |(e1 & effE);
      expFlags.match2DE = |(e2 & effE);
      checkFlags(matchOut, expFlags);
      checkVector(vectorPcNextF, vectorSelectW, vectorTarget(vectorReqW), |vectorReqW);
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ============================
  // Stimulus
  // ============================

  task automatic driveRandom(input bit allowStall);
    logic [31:0] r;
    logic [31:0] q;
    logic [4:0] m;
    r = $urandom;
    q = $urandom;
    instrD = $urandom;
    instrE = $urandom;
    opCtrlD = opSelCtrl_t'(r[3:0]);
    // Mostly legal modes, one case in eight a raw field
    case (r[6:4])
      3'd0: m = USER;
      3'd1: m = FIQ;
      3'd2: m = IRQ;
      3'd3: m = SVC;
      3'd4: m = ABT;
      3'd5: m = UND;
      3'd6: m = SYS;
      default: m = q[4:0];
    endcase
    statusW = {r[9:7], m};
    swiE = (r[12:10] == 3'd0);
    writeMultLoE = (r[14:13] == 2'd0);
    vectorReqW = (r[17:15] == 3'd0) ? '0 : (q[11:5] & q[18:12]);
    stallE = allowStall && (r[19:18] == 2'd0);
    stallM = allowStall && (r[21:20] == 2'd0);
    stallW = allowStall && (r[23:22] == 2'd0);
    flushW = allowStall && (r[26:24] == 3'd0);
  endtask

  initial begin
    instrD = '0;
    instrE = '0;
    opCtrlD = '0;
    writeMultLoE = 1'b0;
    swiE = 1'b0;
    stallE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    statusW = '0;
    vectorReqW = '0;
    selErrors = 0;
    flagErrors = 0;
    vectorErrors = 0;
    cycleCount = 0;
    void'($urandom(63));
    // Cleared state while reset is still held
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkSel("wa3W in reset", wa3W, '0);
    checkFlags(matchOut, '0);
    checkVector(vectorPcNextF, vectorSelectW, HIGH_BASE, 1'b0);
    wait (!reset);
    for (int i = 0; i < STIM_CYCLES; i++) begin
      @(posedge clk);
      #1 driveRandom(i >= CLEAN_CYCLES);
    end
    @(negedge clk);
    #1;
    $display("Summary: %0d select errors, %0d flag errors, %0d vector errors",
             selErrors, flagErrors, vectorErrors);
    if (selErrors + flagErrors + vectorErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/armAddrPkg.sv
hw/operandSelect.sv
hw/bankedRegDecode.sv
hw/exceptionVector.sv
hw/addressPath.sv
testbench/clockGen.sv
testbench/addressPathTb.sv

// ==== Makefile ====
# Verilator build and run of the address path testbench

TOP = addressPathTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
